// ==== hdl/clkCfgPkg.sv ====
package clkCfgPkg;

    // Divisor field of the clock configuration word
    localparam int DivWidth = 14;

    // 0 picks the system clock, 1 to 3 pick sources 0 to 2
    typedef logic [1:0] clkSel_t;

    typedef struct packed {
        clkSel_t               sel;
        logic [DivWidth-1:0]   divisor;
    } clkCfg_t;

    // Byte addresses of the two 8-bit configuration registers
    localparam logic [7:0] CfgLowerAddr = 8'h00;
    localparam logic [7:0] CfgUpperAddr = 8'h04;

endpackage

// ==== hdl/apbPkg.sv ====
package apbPkg;

    localparam int AddrWidth = 8;
    localparam int DataWidth = 16;

    // Master to slave
    typedef struct packed {
        logic                 psel;
        logic                 penable;
        logic                 pwrite;
        logic [AddrWidth-1:0] paddr;
        logic [DataWidth-1:0] pwdata;
    } apbReq_t;

    // Slave to master
    typedef struct packed {
        logic                 pready;
        logic [DataWidth-1:0] prdata;
    } apbRsp_t;

endpackage

// ==== hdl/apbClkCfgRegs.sv ====
`timescale 1ns/1ps

module apbClkCfgRegs (
    input  logic                 pclk,
    input  logic                 rstN,
    input  apbPkg::apbReq_t      apbReq,
    output apbPkg::apbRsp_t      apbRsp,
    output logic                 cfgPush,
    output clkCfgPkg::clkCfg_t   cfgWord
);

    logic       accessPhase;
    logic       wrLower;
    logic       wrUpper;
    logic [7:0] upperReg;
    logic [7:0] lowerReg;
    logic [1:0] submitDly;

    // No wait states, so every access phase completes
    assign accessPhase = apbReq.psel & apbReq.penable;

    assign wrLower = accessPhase & apbReq.pwrite & (apbReq.paddr == clkCfgPkg::CfgLowerAddr);
    assign wrUpper = accessPhase & apbReq.pwrite & (apbReq.paddr == clkCfgPkg::CfgUpperAddr);

    // Both byte registers take pwdata[7:0]
    always_ff @(posedge pclk or negedge rstN) begin
        if (!rstN) begin
            lowerReg <= 8'h00;
        end else if (wrLower) begin
            lowerReg <= apbReq.pwdata[7:0];
        end
    end

    always_ff @(posedge pclk or negedge rstN) begin
        if (!rstN) begin
            upperReg <= 8'h00;
        end else if (wrUpper) begin
            upperReg <= apbReq.pwdata[7:0];
        end
    end

    // Submit delay
    // stage 0 sets on the upper write edge, the FIFO samples stage 1 two edges later
    always_ff @(posedge pclk or negedge rstN) begin
        if (!rstN) begin
            submitDly <= 2'b00;
        end else begin
            submitDly <= {submitDly[0], wrUpper};
        end
    end

    assign cfgPush = submitDly[1];

    // Select in the top bits of the upper byte, divisor spans both bytes
    assign cfgWord = clkCfgPkg::clkCfg_t'({upperReg, lowerReg});

    // Readback is the full word whatever the address
    assign apbRsp.pready = accessPhase;
    assign apbRsp.prdata = {upperReg, lowerReg};

endmodule

// ==== hdl/cfgCdcFifo.sv ====
`timescale 1ns/1ps

module cfgCdcFifo #(
    parameter int Depth = 4
) (
    input  logic                 wrClk,
    input  logic                 rstN,
    input  logic                 push,
    input  clkCfgPkg::clkCfg_t   din,
    input  logic                 rdClk,
    input  logic                 pop,
    input  logic                 clkEn,
    output logic                 valid,
    output clkCfgPkg::clkCfg_t   dout
);

    localparam int AddrW = $clog2(Depth);
    localparam int PtrW  = AddrW + 1;
    // Gray pointers differ in the top two bits only when full
    localparam logic [PtrW-1:0] FullMask = PtrW'(3) << (PtrW - 2);

    clkCfgPkg::clkCfg_t mem [Depth];

    logic [1:0]      wrRstPipe;
    logic [1:0]      rdRstPipe;
    logic            wrRstN;
    logic            rdRstN;
    logic [PtrW-1:0] wrPtrBin;
    logic [PtrW-1:0] wrPtrGray;
    logic [PtrW-1:0] rdPtrBin;
    logic [PtrW-1:0] rdPtrGray;
    logic [PtrW-1:0] rdGrayMeta;
    logic [PtrW-1:0] rdGraySync;
    logic [PtrW-1:0] wrGrayMeta;
    logic [PtrW-1:0] wrGraySync;
    logic [PtrW-1:0] wrPtrNext;
    logic [PtrW-1:0] rdPtrNext;
    logic            full;
    logic            empty;
    logic            pushOk;
    logic            popOk;

    // Reset synchronizers, asynchronous assert and synchronous release
    always_ff @(posedge wrClk or negedge rstN) begin
        if (!rstN) begin
            wrRstPipe <= 2'b00;
        end else begin
            wrRstPipe <= {wrRstPipe[0], 1'b1};
        end
    end

    always_ff @(posedge rdClk or negedge rstN) begin
        if (!rstN) begin
            rdRstPipe <= 2'b00;
        end else begin
            rdRstPipe <= {rdRstPipe[0], 1'b1};
        end
    end

    assign wrRstN = wrRstPipe[1];
    assign rdRstN = rdRstPipe[1];

    // Write side
    assign full      = (wrPtrGray ^ rdGraySync) == FullMask;
    assign pushOk    = push & ~full;
    assign wrPtrNext = wrPtrBin + 1'b1;

    always_ff @(posedge wrClk) begin
        if (pushOk) begin
            mem[wrPtrBin[AddrW-1:0]] <= din;
        end
    end

    always_ff @(posedge wrClk or negedge wrRstN) begin
        if (!wrRstN) begin
            wrPtrBin   <= '0;
            wrPtrGray  <= '0;
            rdGrayMeta <= '0;
            rdGraySync <= '0;
        end else begin
            rdGrayMeta <= rdPtrGray;
            rdGraySync <= rdGrayMeta;
            if (pushOk) begin
                wrPtrBin  <= wrPtrNext;
                wrPtrGray <= wrPtrNext ^ (wrPtrNext >> 1);
            end
        end
    end

    // Read side, pointer holds while clkEn is low
    assign empty     = rdPtrGray == wrGraySync;
    assign popOk     = pop & clkEn & ~empty;
    assign rdPtrNext = rdPtrBin + 1'b1;

    always_ff @(posedge rdClk or negedge rdRstN) begin
        if (!rdRstN) begin
            rdPtrBin   <= '0;
            rdPtrGray  <= '0;
            wrGrayMeta <= '0;
            wrGraySync <= '0;
        end else begin
            wrGrayMeta <= wrPtrGray;
            wrGraySync <= wrGrayMeta;
            if (popOk) begin
                rdPtrBin  <= rdPtrNext;
                rdPtrGray <= rdPtrNext ^ (rdPtrNext >> 1);
            end
        end
    end

    assign valid = ~empty;
    assign dout  = mem[rdPtrBin[AddrW-1:0]];

endmodule

// ==== hdl/clkDivider.sv ====
`timescale 1ns/1ps

module clkDivider (
    input  logic                 divided_clk_src,
    input  logic                 rstN,
    input  logic                 clkEn,
    input  logic                 cfgValid,
    input  clkCfgPkg::clkCfg_t   cfgIn,
    output logic                 cfgPop,
    output logic                 dividedClk,
    output clkCfgPkg::clkSel_t   dividedClkSel
);

    clkCfgPkg::clkCfg_t                cfgReg;
    logic [clkCfgPkg::DivWidth-1:0]    divCnt;
    logic                              elapsed;
    logic                              clkFf;

    // Pop and load in the same cycle
    assign cfgPop  = cfgValid & clkEn;
    assign elapsed = divCnt == cfgReg.divisor;

    always_ff @(posedge divided_clk_src or negedge rstN) begin
        if (!rstN) begin
            cfgReg <= '0;
            divCnt <= '0;
            clkFf  <= 1'b0;
        end else if (clkEn) begin
            if (cfgPop) begin
                // New word restarts the count, toggle phase kept
                cfgReg <= cfgIn;
                divCnt <= '0;
            end else if (elapsed) begin
                divCnt <= '0;
                clkFf  <= ~clkFf;
            end else begin
                divCnt <= divCnt + 1'b1;
            end
        end
    end

    assign dividedClk    = clkFf;
    assign dividedClkSel = cfgReg.sel;

endmodule

// ==== hdl/ioClkGenCell.sv ====
`timescale 1ns/1ps

module ioClkGenCell #(
    parameter int FifoDepth = 4
) (
    input  logic                 pclk,
    input  logic                 divided_clk_src,
    input  logic                 rstN,
    input  logic                 clkEn,
    input  apbPkg::apbReq_t      apbReq,
    output apbPkg::apbRsp_t      apbRsp,
    output logic                 dividedClk,
    output clkCfgPkg::clkSel_t   dividedClkSel
);

    logic               cfgPush;
    clkCfgPkg::clkCfg_t cfgWord;
    logic               cfgValid;
    clkCfgPkg::clkCfg_t cfgOut;
    logic               cfgPop;

    apbClkCfgRegs u_apbClkCfgRegs (
        .pclk    (pclk),
        .rstN    (rstN),
        .apbReq  (apbReq),
        .apbRsp  (apbRsp),
        .cfgPush (cfgPush),
        .cfgWord (cfgWord)
    );

    // Bus clock to selected source clock
    cfgCdcFifo #(
        .Depth (FifoDepth)
    ) u_cfgCdcFifo (
        .wrClk (pclk),
        .rstN  (rstN),
        .push  (cfgPush),
        .din   (cfgWord),
        .rdClk (divided_clk_src),
        .pop   (cfgPop),
        .clkEn (clkEn),
        .valid (cfgValid),
        .dout  (cfgOut)
    );

    clkDivider u_clkDivider (
        .divided_clk_src (divided_clk_src),
        .rstN            (rstN),
        .clkEn           (clkEn),
        .cfgValid        (cfgValid),
        .cfgIn           (cfgOut),
        .cfgPop          (cfgPop),
        .dividedClk      (dividedClk),
        .dividedClkSel   (dividedClkSel)
    );

endmodule

// ==== tests/ioClkGenCell_sva.sv ====
`timescale 1ns/1ps

module ioClkGenCell_sva #(
    parameter bit BusSide = 1'b1
) (
    input logic       clk,
    input logic       rstN,
    input logic       psel,
    input logic       penable,
    input logic       pwrite,
    input logic [7:0] paddr,
    input logic       push,
    input logic       full
);

    int assertFails = 0;

    if (BusSide) begin : gBus
        logic upperWrite;

        // Upper byte write as seen on the bus
        assign upperWrite = psel & penable & pwrite
                            & (paddr == clkCfgPkg::CfgUpperAddr);

        setupToAccess: assert property (@(posedge clk) disable iff (!rstN)
            (psel && !penable) |=> (psel && penable))
            else begin
                assertFails++;
                $error("penable did not follow the setup phase");
            end
        accessNeedsSel: assert property (@(posedge clk) disable iff (!rstN) penable |-> psel)
            else begin
                assertFails++;
                $error("penable high without psel");
            end
        pushPulse: assert property (@(posedge clk) disable iff (!rstN) push |=> !push)
            else begin
                assertFails++;
                $error("cfgPush stayed high for more than one cycle");
            end
        // Commit lands two cycles after the upper write
        submitDelay: assert property (@(posedge clk) disable iff (!rstN)
            push == $past(upperWrite, 2))
            else begin
                assertFails++;
                $error("cfgPush does not follow an upper write by two cycles");
            end
    end else begin : gFifo
        pushNotFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
            else begin
                assertFails++;
                $error("Configuration word pushed into a full FIFO");
            end
    end

endmodule

bind apbClkCfgRegs ioClkGenCell_sva #(.BusSide(1'b1)) busSva (
    .clk     (pclk),
    .rstN    (rstN),
    .psel    (apbReq.psel),
    .penable (apbReq.penable),
    .pwrite  (apbReq.pwrite),
    .paddr   (apbReq.paddr),
    .push    (cfgPush),
    .full    (1'b0)
);

bind cfgCdcFifo ioClkGenCell_sva #(.BusSide(1'b0)) fifoSva (
    .clk     (wrClk),
    .rstN    (rstN),
    .psel    (1'b0),
    .penable (1'b0),
    .pwrite  (1'b0),
    .paddr   (8'h00),
    .push    (push),
    .full    (full)
);

// ==== tests/ioClkGenCellTb.sv ====
`timescale 1ns/1ps

module ioClkGenCellTb;

    localparam string StimFile = "tests/ioClkGenStim.txt";
    // Two full periods of the largest divisor in the file fit in this
    localparam int    MaxCycles = 1000;

    logic               pclk;
    logic               divided_clk_src;
    logic               rstN;
    logic               clkEn;
    apbPkg::apbReq_t    apbReq;
    apbPkg::apbRsp_t    apbRsp;
    logic               dividedClk;
    clkCfgPkg::clkSel_t dividedClkSel;

    int          errorCount = 0;
    int          stimLines = 0;
    logic        stimReady = 1'b0;
    logic [63:0] opQ[$];
    logic [7:0]  addrQ[$];
    logic [15:0] dataQ[$];
    logic [15:0] expQ[$];

    ioClkGenCell #(
        .FifoDepth (4)
    ) u_ioClkGenCell (
        .pclk            (pclk),
        .divided_clk_src (divided_clk_src),
        .rstN            (rstN),
        .clkEn           (clkEn),
        .apbReq          (apbReq),
        .apbRsp          (apbRsp),
        .dividedClk      (dividedClk),
        .dividedClkSel   (dividedClkSel)
    );

    always #5 divided_clk_src = ~divided_clk_src;
    // Bus clock, unrelated to the source
    always #7 pclk = ~pclk;

    task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errorCount++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic readStim();
        int              fd;
        int              fields;
        logic [8*96-1:0] lineBuf;
        logic [63:0]     op;
        logic [7:0]      addr;
        logic [15:0]     data;
        logic [15:0]     exp;
        fd = $fopen(StimFile, "r");
        if (fd == 0) begin
            errorCount++;
            $display("Could not open the stimulus file %s", StimFile);
        end else begin
            lineBuf = '0;
            while ($fgets(lineBuf, fd) != 0) begin
                stimLines++;
                // Comment lines give fewer than four fields
                fields = $sscanf(lineBuf, "%s %h %h %h", op, addr, data, exp);
                if (fields == 4) begin
                    opQ.push_back(op);
                    addrQ.push_back(addr);
                    dataQ.push_back(data);
                    expQ.push_back(exp);
                end
                lineBuf = '0;
            end
            $fclose(fd);
        end
    endtask

    // Setup then access phase, random idle gap in front
    task automatic apbTransfer(input logic wr, input logic [7:0] addr,
                               input logic [15:0] wdata, output logic [15:0] rdata);
        int gap;
        gap = $urandom % 4;
        repeat (gap) @(posedge pclk);
        @(posedge pclk);
        #1;
        apbReq.psel    = 1'b1;
        apbReq.penable = 1'b0;
        apbReq.pwrite  = wr;
        apbReq.paddr   = addr;
        apbReq.pwdata  = wdata;
        @(posedge pclk);
        #1;
        apbReq.penable = 1'b1;
        #5;
        checkEq("pready", apbRsp.pready, 1'b1);
        rdata = apbRsp.prdata;
        @(posedge pclk);
        #1;
        apbReq = '0;
    endtask

    task automatic waitSel(input logic [1:0] exp);
        int n;
        n = 0;
        while (dividedClkSel !== exp && n < MaxCycles) begin
            @(posedge divided_clk_src);
            #1;
            n++;
        end
        if (dividedClkSel !== exp) begin
            errorCount++;
            $display("Timed out at %0t ns waiting for dividedClkSel to become %0d", $time, exp);
        end
    endtask

    // Source cycles from one rising edge of dividedClk to the next
    task automatic measurePeriod(input logic [15:0] exp);
        int   n;
        int   rises;
        int   cycles;
        logic prev;
        n = 0;
        rises = 0;
        cycles = 0;
        prev = dividedClk;
        while (rises < 2 && n < MaxCycles) begin
            @(posedge divided_clk_src);
            #1;
            n++;
            if (rises == 1) cycles++;
            if (dividedClk && !prev) rises++;
            prev = dividedClk;
        end
        if (rises < 2) begin
            errorCount++;
            $display("Timed out at %0t ns, dividedClk did not complete a period", $time);
        end else begin
            checkEq("dividedClk period", cycles, exp);
        end
    endtask

    task automatic holdLevel(input logic [15:0] cycles);
        logic level;
        level = dividedClk;
        repeat (cycles) begin
            @(posedge divided_clk_src);
            #1;
            checkEq("dividedClk", dividedClk, level);
        end
    endtask

    initial begin : watchdog
        wait (stimReady);
        #((stimLines + 1) * 2000);
        $display("Watchdog expired after %0d ns, the run timed out", (stimLines + 1) * 2000);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [15:0] rdata;
        void'($urandom(32'h5ac3_e10c));
        pclk = 1'b0;
        divided_clk_src = 1'b0;
        rstN = 1'b0;
        clkEn = 1'b1;
        apbReq = '0;
        readStim();
        stimReady = 1'b1;
        repeat (4) @(posedge divided_clk_src);
        #1;
        checkEq("dividedClk", dividedClk, 1'b0);
        checkEq("pready", apbRsp.pready, 1'b0);
        rstN = 1'b1;
        for (int i = 0; i < opQ.size(); i++) begin
            case (opQ[i])
                "write": apbTransfer(1'b1, addrQ[i], dataQ[i], rdata);
                "read": begin
                    apbTransfer(1'b0, addrQ[i], 16'h0000, rdata);
                    checkEq("prdata", rdata, expQ[i]);
                end
                "idle": repeat (dataQ[i]) @(posedge pclk);
                "sel": waitSel(expQ[i][1:0]);
                "period": measurePeriod(expQ[i]);
                "clken": begin
                    @(posedge divided_clk_src);
                    #1;
                    clkEn = dataQ[i][0];
                end
                "hold": holdLevel(dataQ[i]);
                default: begin
                    errorCount++;
                    $display("Unknown operation in stimulus step %0d", i);
                end
            endcase
        end
        errorCount += u_ioClkGenCell.u_apbClkCfgRegs.busSva.assertFails;
        errorCount += u_ioClkGenCell.u_cfgCdcFifo.fifoSva.assertFails;
        $display("Finished %0d steps with %0d errors", opQ.size(), errorCount);
        if (errorCount == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== tests/ioClkGenStim.txt ====
# stimulus op addr data expect, numbers in hex
# read checks prdata, period counts source cycles, sel waits, hold counts cycles
sel    00 0000 0000
period 00 0000 0002
write  00 0005 0000
idle   00 0004 0000
read   04 0000 0005
period 00 0000 0002
sel    00 0000 0000
write  04 0040 0000
read   00 0000 4005
sel    00 0000 0001
period 00 0000 000c
write  00 0001 0000
write  04 0080 0000
sel    00 0000 0002
period 00 0000 0004
write  00 00c8 0000
write  04 00c0 0000
read   04 0000 c0c8
sel    00 0000 0003
period 00 0000 0192
write  00 0000 0000
write  04 0040 0000
write  04 0080 0000
sel    00 0000 0002
period 00 0000 0002
clken  00 0000 0000
hold   00 0014 0000
clken  00 0001 0000
period 00 0000 0002

// ==== ioClkGen.f ====
hdl/clkCfgPkg.sv
hdl/apbPkg.sv
hdl/apbClkCfgRegs.sv
hdl/cfgCdcFifo.sv
hdl/clkDivider.sv
hdl/ioClkGenCell.sv
tests/ioClkGenCell_sva.sv
tests/ioClkGenCellTb.sv

// ==== Makefile ====
TOP = ioClkGenCellTb
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) -f ioClkGen.f

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

lint:
	verilator --lint-only --timing --assert -Wall --top-module $(TOP) -f ioClkGen.f

clean:
	rm -rf obj_dir $(LOG)
